/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= pa_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
logic/pa_pkg.sv
logic/pa_bus_w.sv
logic/pa_alu.sv
logic/pa_regs.sv
logic/pa_bus_a.sv
logic/pa_addr.sv
logic/pa.sv
sim/pa_tb.sv

/* logic/pa.sv */
//**********************************************************
// arithmetic and register unit top level
// W bus, A bus, ALU, registers and address stage
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

module pa (
	input  wire logic             __clk,
	input  wire logic             rst,
	input  wire pa_pkg::word_t    ir,
	input  wire pa_pkg::word_t    kl,
	input  wire pa_pkg::word_t    rdt,
	input  wire pa_pkg::word_t    ki,
	input  wire pa_pkg::word_t    l,
	input  wire pa_pkg::w_sel_t   w_sel,
	input  wire pa_pkg::a_sel_t   a_sel,
	input  wire pa_pkg::alu_ctl_t alu,
	input  wire pa_pkg::strobe_t  strb,
	input  wire pa_pkg::reg_ctl_t rctl,
	input  wire logic             axy,
	input  wire logic             ar_ad,
	input  wire logic             ic_ad,
	input  wire logic             barnb,
	output pa_pkg::word_t         w,
	output pa_pkg::word_t         ddt,
	output pa_pkg::word_t         dad,
	output logic                  s0,
	output logic                  carry,
	output logic                  s_1,
	output logic                  zs,
	output logic                  wzi,
	output logic                  exx,
	output logic                  exy,
	output logic                  at15,
	output logic                  arz,
	output logic                  zga
);

	import pa_pkg::*;

	word_t a;
	word_t f;
	word_t at;
	word_t ac;
	word_t ar;
	word_t ic;

	assign at15 = at[15];

	pa_bus_w u_bus_w (
		.sel  (w_sel),
		.ir   (ir),
		.kl   (kl),
		.rdt  (rdt),
		.ki   (ki),
		.at   (at),
		.ac   (ac),
		.a    (a),
		.w_dt (rctl.w_dt),
		.w    (w),
		.ddt  (ddt)
	);

	pa_bus_a u_bus_a (
		.sel (a_sel),
		.l   (l),
		.ir  (ir),
		.ar  (ar),
		.ic  (ic),
		.a   (a)
	);

	pa_alu u_alu (
		.a     (a),
		.ac    (ac),
		.ctl   (alu),
		.ir6   (ir[6]),
		.at15  (at[15]),
		.axy   (axy),
		.f     (f),
		.carry (carry),
		.s0    (s0),
		.s_1   (s_1),
		.zs    (zs),
		.exx   (exx),
		.exy   (exy)
	);

	pa_regs u_regs (
		.__clk (__clk),
		.rst   (rst),
		.strb  (strb),
		.ctl   (rctl),
		.w     (w),
		.f     (f),
		.zs    (zs),
		.at    (at),
		.ac    (ac),
		.ar    (ar),
		.ic    (ic),
		.wzi   (wzi),
		.arz   (arz)
	);

	pa_addr u_addr (
		.ar    (ar),
		.ic    (ic),
		.kl    (kl),
		.ar_ad (ar_ad),
		.ic_ad (ic_ad),
		.barnb (barnb),
		.dad   (dad),
		.zga   (zga)
	);

endmodule

`default_nettype wire

/* logic/pa_addr.sv */
//**********************************************************
// address line drive from AR and IC
// key line comparator
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

module pa_addr (
	input  wire pa_pkg::word_t ar,
	input  wire pa_pkg::word_t ic,
	input  wire pa_pkg::word_t kl,
	input  wire logic          ar_ad,
	input  wire logic          ic_ad,
	input  wire logic          barnb,
	output pa_pkg::word_t      dad,
	output logic               zga
);

	import pa_pkg::*;

	word_t ar_drv;
	word_t ic_drv;
	word_t cmp_addr;

	// both gates open just wire-OR the lines
	assign ar_drv = ar_ad ? ar : '0;
	assign ic_drv = ic_ad ? ic : '0;
	assign dad = ar_drv | ic_drv;

	// bit 0 stands for the memory block, taken from barnb
	assign cmp_addr = {~barnb, dad[1:15]};
	assign zga = (kl == cmp_addr);

endmodule

`default_nettype wire

/* logic/pa_alu.sv */
//**********************************************************
// 74181-style ALU, A bus against the accumulator
// carry out of bit 0, extended sign, zero flag
// and the two condition outputs exx and exy
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

module pa_alu (
	input  wire pa_pkg::word_t    a,
	input  wire pa_pkg::word_t    ac,
	input  wire pa_pkg::alu_ctl_t ctl,
	input  wire logic             ir6,
	input  wire logic             at15,
	input  wire logic             axy,
	output pa_pkg::word_t         f,
	output logic                  carry,
	output logic                  s0,
	output logic                  s_1,
	output logic                  zs,
	output logic                  exx,
	output logic                  exy
);

	import pa_pkg::*;

	word_t       x_op;
	word_t       y_op;
	logic [16:0] sum;
	logic        ext;

	// per-bit terms of the 74181, S0/S1 pick the first operand
	// and S2/S3 the second one
	always_comb begin
		x_op = a | (ac & {WORD_W{ctl.fn[0]}}) | (~ac & {WORD_W{ctl.fn[1]}});
		y_op = (a & ~ac & {WORD_W{ctl.fn[2]}}) | (a & ac & {WORD_W{ctl.fn[3]}});
	end

	// bit 0 is the msb, so the plain vector sum carries out of it
	assign sum = {1'b0, x_op} + {1'b0, y_op} + {16'd0, ctl.cin};

	assign carry = sum[16];
	assign f = ctl.mode ? ~(x_op ^ y_op) : sum[15:0];
	assign s0 = f[0];

	// sign one bit beyond the word
	always_comb begin
		case (ctl.ext_sel)
			EXT_AM1: ext = ~a[0];
			EXT_APB: ext = a[0] ^ ac[0];
			EXT_AMB: ext = ~(a[0] ^ ac[0]);
			EXT_AP1: ext = a[0];
			default: ext = 1'b0;
		endcase
	end

	assign s_1 = ext ^ carry;

	// zero only when the extended sign agrees
	assign zs = ~s_1 & (f == '0);

	// condition lines for the control unit
	assign exx = ir6 ? a[15] : a[0];
	assign exy = axy ? at15 : a[0];

endmodule

`default_nettype wire

/* logic/pa_bus_a.sv */
//**********************************************************
// A bus source multiplexer
// argument extension from IR, AR, IC and L
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

module pa_bus_a (
	input  wire pa_pkg::a_sel_t sel,
	input  wire pa_pkg::word_t  l,
	input  wire pa_pkg::word_t  ir,
	input  wire pa_pkg::word_t  ar,
	input  wire pa_pkg::word_t  ic,
	output pa_pkg::word_t       a
);

	import pa_pkg::*;

	word_t short_arg;
	word_t long_arg;

	// short argument sits in ir 10..15, bit 10 is its sign
	assign short_arg = {{10{ir[10]}}, ir[10:15]};

	// ir 7..15 as an unsigned field
	assign long_arg = {7'd0, ir[7:15]};

	always_comb begin
		case (sel)
			A_ZERO:  a = '0;
			A_L:     a = l;
			A_SHORT: a = short_arg;
			A_AR:    a = ar;
			A_IC:    a = ic;
			A_IRLO:  a = long_arg;
			A_ONES:  a = '1;
			A_ZERO2: a = '0;
			default: a = '0;
		endcase
	end

endmodule

`default_nettype wire

/* logic/pa_bus_w.sv */
//**********************************************************
// W bus source multiplexer
// feeds every register load and the gated data output
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

module pa_bus_w (
	input  wire pa_pkg::w_sel_t sel,
	input  wire pa_pkg::word_t  ir,
	input  wire pa_pkg::word_t  kl,
	input  wire pa_pkg::word_t  rdt,
	input  wire pa_pkg::word_t  ki,
	input  wire pa_pkg::word_t  at,
	input  wire pa_pkg::word_t  ac,
	input  wire pa_pkg::word_t  a,
	input  wire logic           w_dt,
	output pa_pkg::word_t       w,
	output pa_pkg::word_t       ddt
);

	import pa_pkg::*;

	always_comb begin
		case (sel)
			W_IR:   w = ir;
			W_KL:   w = kl;
			W_RDT:  w = rdt;
			W_KI:   w = ki;
			W_AT:   w = at;
			W_AC:   w = ac;
			W_A:    w = a;
			W_ZERO: w = '0;
			default: w = '0;
		endcase
	end

	// data lines only see W while w_dt is up
	assign ddt = w_dt ? w : '0;

	// an idle W bus must never leak onto the data lines
	always_comb begin
		assert ((sel != W_ZERO) || (ddt == '0))
			else $error("data lines not clear with W bus idle");
	end

endmodule

`default_nettype wire

/* logic/pa_pkg.sv */
//**********************************************************
// shared types for the arithmetic and register unit
// word type (bit 0 is the msb), W and A bus select codes,
// sign-extension codes and control structs
//**********************************************************

`default_nettype none

package pa_pkg;

	localparam int WORD_W = 16;

	// bit 0 is the most significant
	typedef logic [0:WORD_W-1] word_t;

	typedef logic [2:0] w_sel_t;
	typedef logic [2:0] a_sel_t;
	typedef logic [3:0] alu_fn_t;
	typedef logic [1:0] ext_sel_t;

	// W bus sources
	localparam w_sel_t W_IR   = 3'd0;
	localparam w_sel_t W_KL   = 3'd1;
	localparam w_sel_t W_RDT  = 3'd2;
	localparam w_sel_t W_KI   = 3'd3;
	localparam w_sel_t W_AT   = 3'd4;
	localparam w_sel_t W_AC   = 3'd5;
	localparam w_sel_t W_A    = 3'd6;
	localparam w_sel_t W_ZERO = 3'd7;

	// A bus sources
	localparam a_sel_t A_ZERO  = 3'd0;
	localparam a_sel_t A_L     = 3'd1;
	localparam a_sel_t A_SHORT = 3'd2;
	localparam a_sel_t A_AR    = 3'd3;
	localparam a_sel_t A_IC    = 3'd4;
	localparam a_sel_t A_IRLO  = 3'd5;
	localparam a_sel_t A_ONES  = 3'd6;
	localparam a_sel_t A_ZERO2 = 3'd7;

	// sign-extension formulas
	localparam ext_sel_t EXT_AM1 = 2'd0;
	localparam ext_sel_t EXT_APB = 2'd1;
	localparam ext_sel_t EXT_AMB = 2'd2;
	localparam ext_sel_t EXT_AP1 = 2'd3;

	typedef struct packed {
		alu_fn_t  fn;
		logic     mode;
		logic     cin;
		ext_sel_t ext_sel;
	} alu_ctl_t;

	typedef struct packed {
		logic strob1b;
		logic strob2b;
		logic as2;
	} strobe_t;

	typedef struct packed {
		logic w_ac;
		logic w_ar;
		logic arp1;
		logic arm4;
		logic w_ic;
		logic icp1;
		logic off;
		logic wx;
		logic eat0;
		logic w_dt;
	} reg_ctl_t;

endpackage

`default_nettype wire

/* logic/pa_regs.sv */
//**********************************************************
// AT, AC, AR and IC registers and the WZI flag
// strobe gating for loads, shifts and counting
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

module pa_regs (
	input  wire logic             __clk,
	input  wire logic             rst,
	input  wire pa_pkg::strobe_t  strb,
	input  wire pa_pkg::reg_ctl_t ctl,
	input  wire pa_pkg::word_t    w,
	input  wire pa_pkg::word_t    f,
	input  wire logic             zs,
	output pa_pkg::word_t         at,
	output pa_pkg::word_t         ac,
	output pa_pkg::word_t         ar,
	output pa_pkg::word_t         ic,
	output logic                  wzi,
	output logic                  arz
);

	import pa_pkg::*;

	logic stroba;
	logic strobb;
	logic ac_load;
	logic ar_load;
	logic ar_step;
	logic ic_load;
	logic ic_step;
	logic at_load;
	logic at_shift;

	// first strobe outside as2, second strobe inside it
	assign stroba = strb.strob1b & ~strb.as2;
	assign strobb = strb.strob2b & strb.as2;

	assign ac_load  = ctl.w_ac & (stroba | strobb);
	assign ar_load  = ctl.w_ar & (stroba | strobb);
	assign ar_step  = ctl.arp1 & stroba;
	assign ic_load  = ctl.w_ic & (stroba | strobb);
	assign ic_step  = ctl.icp1 & strb.strob1b;
	assign at_load  = strb.as2 & strb.strob1b;
	assign at_shift = ctl.wx & strb.strob1b;

	always_ff @(posedge __clk) begin
		if (rst) begin
			at  <= '0;
			ac  <= '0;
			ar  <= '0;
			ic  <= '0;
			wzi <= 1'b0;
		end else begin
			// load beats shift, as on the 74194
			if (at_load)
				at <= f;
			else if (at_shift)
				at <= {ctl.eat0, at[0:14]};

			if (ac_load)
				ac <= w;

			// arm4 turns the increment into a step back
			if (ar_load)
				ar <= w;
			else if (ar_step)
				ar <= ctl.arm4 ? ar - 16'd1 : ar + 16'd1;

			if (ctl.off)
				ic <= '0;
			else if (ic_load)
				ic <= w;
			else if (ic_step)
				ic <= ic + 16'd1;

			// adder zero caught with the AT load
			if (at_load)
				wzi <= zs;
		end
	end

	// upper byte of AR
	assign arz = |ar[0:7];

	a_ic_off: assert property (@(posedge __clk) disable iff (rst)
		ctl.off |=> (ic == '0))
		else $error("IC not cleared after off");

	a_ar_load_wins: assert property (@(posedge __clk) disable iff (rst)
		(ar_load && ar_step) |=> (ar == $past(w)))
		else $error("AR step overrode a load");

endmodule

`default_nettype wire

/* sim/pa_tb.sv */
//**********************************************************
// testbench for the arithmetic and register unit
// clock, reset, reference model, stimulus table,
// compare task and cycle limit
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

module pa_tb;

	import pa_pkg::*;

	// tb vectors are [15:0], so plan bit k is vector bit 15-k
	typedef struct packed {
		logic [15:0] ir;
		logic [15:0] kl;
		logic [15:0] rdt;
		logic [15:0] ki;
		logic [15:0] l;
		w_sel_t      w_sel;
		a_sel_t      a_sel;
		alu_ctl_t    alu;
		strobe_t     strb;
		reg_ctl_t    rctl;
		logic        axy;
		logic        ar_ad;
		logic        ic_ad;
		logic        barnb;
	} stim_t;

	typedef struct packed {
		logic [15:0] w;
		logic [15:0] ddt;
		logic [15:0] dad;
		logic        s0;
		logic        carry;
		logic        s_1;
		logic        zs;
		logic        wzi;
		logic        exx;
		logic        exy;
		logic        at15;
		logic        arz;
		logic        zga;
	} resp_t;

	// mask bits: 0 data, 1 address, 2 adder flags, 3 wzi, 4 conditions
	localparam logic [4:0] CHK_ALL = 5'h1f;

	// strob1b alone, AT load with as2, second strobe with as2
	localparam strobe_t STB_A  = 3'b100;
	localparam strobe_t STB_AT = 3'b101;
	localparam strobe_t STB_B  = 3'b011;

	logic        __clk;
	logic        rst;
	stim_t       drv;
	resp_t       got;
	word_t       w_o;
	word_t       ddt_o;
	word_t       dad_o;

	stim_t       stim_q[$];
	resp_t       exp_q[$];
	logic [4:0]  mask_q[$];

	// reference model state
	logic [15:0] m_at;
	logic [15:0] m_ac;
	logic [15:0] m_ar;
	logic [15:0] m_ic;
	logic        m_wzi;
	logic        m_wzi_ok;

	logic [31:0] rng;
	int          cycles;
	int          limit;

	pa u_dut (
		.__clk (__clk),
		.rst   (rst),
		.ir    (drv.ir),
		.kl    (drv.kl),
		.rdt   (drv.rdt),
		.ki    (drv.ki),
		.l     (drv.l),
		.w_sel (drv.w_sel),
		.a_sel (drv.a_sel),
		.alu   (drv.alu),
		.strb  (drv.strb),
		.rctl  (drv.rctl),
		.axy   (drv.axy),
		.ar_ad (drv.ar_ad),
		.ic_ad (drv.ic_ad),
		.barnb (drv.barnb),
		.w     (w_o),
		.ddt   (ddt_o),
		.dad   (dad_o),
		.s0    (got.s0),
		.carry (got.carry),
		.s_1   (got.s_1),
		.zs    (got.zs),
		.wzi   (got.wzi),
		.exx   (got.exx),
		.exy   (got.exy),
		.at15  (got.at15),
		.arz   (got.arz),
		.zga   (got.zga)
	);

	assign got.w   = w_o;
	assign got.ddt = ddt_o;
	assign got.dad = dad_o;

	initial begin
		__clk = 1'b0;
		forever #2 __clk = ~__clk;
	end

	function logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function logic [15:0] rand16();
		logic [31:0] r;
		r = next_rand();
		return r[15:0];
	endfunction

	function stim_t idle_stim();
		stim_t s;
		s = '0;
		return s;
	endfunction

	function logic [15:0] a_bus(input stim_t s);
		case (s.a_sel)
			3'd1: return s.l;
			3'd2: return {{10{s.ir[5]}}, s.ir[5:0]};
			3'd3: return m_ar;
			3'd4: return m_ic;
			3'd5: return {7'd0, s.ir[8:0]};
			3'd6: return 16'hffff;
			default: return 16'h0000;
		endcase
	endfunction

	function logic [15:0] w_bus(input stim_t s, input logic [15:0] a);
		case (s.w_sel)
			3'd0: return s.ir;
			3'd1: return s.kl;
			3'd2: return s.rdt;
			3'd3: return s.ki;
			3'd4: return m_at;
			3'd5: return m_ac;
			3'd6: return a;
			default: return 16'h0000;
		endcase
	endfunction

	// {carry, f} for the operations under test, b is the accumulator
	function logic [16:0] alu_result(input alu_ctl_t c, input logic [15:0] a,
			input logic [15:0] b);
		logic [16:0] ci;
		ci = {16'd0, c.cin};
		if (c.mode) begin
			case (c.fn)
				4'b1011: return {1'b0, a & b};
				4'b1110: return {1'b0, a | b};
				4'b0110: return {1'b0, a ^ b};
				4'b1010: return {1'b0, b};
				default: return {1'b0, ~a};
			endcase
		end
		case (c.fn)
			4'b1001: return {1'b0, a} + {1'b0, b} + ci;
			4'b0110: return {1'b0, a} + {1'b0, ~b} + ci;
			4'b1111: return {1'b0, a} + 17'h0ffff + ci;
			default: return {1'b0, a} + ci;
		endcase
	endfunction

	task automatic predict(input stim_t s, output resp_t r);
		logic [15:0] a;
		logic [16:0] cf;
		logic        ext;
		a = a_bus(s);
		cf = alu_result(s.alu, a, m_ac);
		case (s.alu.ext_sel)
			2'd0: ext = ~a[15];
			2'd1: ext = a[15] ^ m_ac[15];
			2'd2: ext = ~(a[15] ^ m_ac[15]);
			default: ext = a[15];
		endcase
		r.w = w_bus(s, a);
		r.ddt = s.rctl.w_dt ? r.w : 16'h0000;
		r.dad = (s.ar_ad ? m_ar : 16'h0000) | (s.ic_ad ? m_ic : 16'h0000);
		r.s0 = cf[15];
		r.carry = cf[16];
		r.s_1 = ext ^ cf[16];
		r.zs = (cf[15:0] == 16'h0000) && !r.s_1;
		r.wzi = m_wzi;
		r.exx = s.ir[9] ? a[0] : a[15];
		r.exy = s.axy ? m_at[0] : a[15];
		r.at15 = m_at[0];
		r.arz = |m_ar[15:8];
		r.zga = (s.kl == {~s.barnb, r.dad[14:0]});
	endtask

	// register actions at the next rising edge
	task automatic advance(input stim_t s, input resp_t r);
		logic [16:0] cf;
		logic        stra;
		logic        strb2;
		cf = alu_result(s.alu, a_bus(s), m_ac);
		stra = s.strb.strob1b && !s.strb.as2;
		strb2 = s.strb.strob2b && s.strb.as2;
		if (s.strb.as2 && s.strb.strob1b) begin
			m_at = cf[15:0];
			m_wzi = r.zs;
			m_wzi_ok = !s.alu.mode;
		end else if (s.rctl.wx && s.strb.strob1b) begin
			m_at = {s.rctl.eat0, m_at[15:1]};
		end
		if (s.rctl.w_ac && (stra || strb2))
			m_ac = r.w;
		if (s.rctl.w_ar && (stra || strb2))
			m_ar = r.w;
		else if (s.rctl.arp1 && stra)
			m_ar = s.rctl.arm4 ? m_ar - 16'd1 : m_ar + 16'd1;
		if (s.rctl.off)
			m_ic = 16'h0000;
		else if (s.rctl.w_ic && (stra || strb2))
			m_ic = r.w;
		else if (s.rctl.icp1 && s.strb.strob1b)
			m_ic = m_ic + 16'd1;
	endtask

	task automatic push_row(input stim_t s);
		resp_t      r;
		logic [4:0] m;
		predict(s, r);
		m = CHK_ALL;
		// adder flags are only defined for arithmetic
		if (s.alu.mode)
			m[2] = 1'b0;
		if (!m_wzi_ok)
			m[3] = 1'b0;
		stim_q.push_back(s);
		exp_q.push_back(r);
		mask_q.push_back(m);
		advance(s, r);
	endtask

	task automatic load_ac(input logic [15:0] b);
		stim_t s;
		s = idle_stim();
		s.kl = b;
		s.w_sel = W_KL;
		s.rctl.w_ac = 1'b1;
		s.strb = STB_A;
		push_row(s);
	endtask

	task automatic alu_case(input logic [3:0] fn, input logic mode, input logic [1:0] ext,
			input logic [15:0] a, input logic [15:0] b, input logic cin);
		stim_t s;
		load_ac(b);
		s = idle_stim();
		s.l = a;
		s.a_sel = A_L;
		s.alu.fn = fn;
		s.alu.mode = mode;
		s.alu.cin = cin;
		s.alu.ext_sel = ext;
		s.strb = STB_AT;
		push_row(s);
		// read AT back and let wzi show
		s = idle_stim();
		s.w_sel = W_AT;
		push_row(s);
	endtask

	task automatic addr_row(input reg_ctl_t c, input strobe_t st, input logic [15:0] v,
			input logic ar_on, input logic ic_on);
		stim_t s;
		s = idle_stim();
		s.kl = v;
		s.w_sel = W_KL;
		s.rctl = c;
		s.strb = st;
		s.ar_ad = ar_on;
		s.ic_ad = ic_on;
		push_row(s);
	endtask

	task automatic build_table();
		stim_t    s;
		reg_ctl_t c;
		logic [15:0] v;
		// reset state on the address lines
		s = idle_stim();
		s.ar_ad = 1'b1;
		s.ic_ad = 1'b1;
		push_row(s);
		// nonzero AT and AC so their W sources show
		alu_case(4'b0000, 1'b0, EXT_AP1, rand16(), rand16(), 1'b0);
		for (int i = 0; i < 8; i++) begin
			s = idle_stim();
			s.ir = rand16();
			s.kl = rand16();
			s.rdt = rand16();
			s.ki = rand16();
			s.l = rand16();
			s.a_sel = A_L;
			s.w_sel = w_sel_t'(i);
			s.rctl.w_dt = i[0];
			push_row(s);
		end
		// add, subtract, increment, decrement with boundaries
		alu_case(4'b1001, 1'b0, EXT_APB, rand16(), rand16(), 1'b0);
		alu_case(4'b1001, 1'b0, EXT_APB, 16'hffff, 16'h0001, 1'b0);
		alu_case(4'b1001, 1'b0, EXT_APB, 16'h8000, 16'h8000, 1'b0);
		alu_case(4'b1001, 1'b0, EXT_APB, 16'h0000, 16'h0000, 1'b0);
		alu_case(4'b0110, 1'b0, EXT_AMB, 16'h1234, 16'h1234, 1'b1);
		alu_case(4'b0110, 1'b0, EXT_AMB, 16'h0000, 16'h0001, 1'b1);
		alu_case(4'b0110, 1'b0, EXT_AMB, rand16(), rand16(), 1'b0);
		alu_case(4'b0000, 1'b0, EXT_AP1, 16'hffff, rand16(), 1'b1);
		alu_case(4'b0000, 1'b0, EXT_AP1, 16'h0000, rand16(), 1'b0);
		alu_case(4'b0000, 1'b0, EXT_AP1, rand16(), rand16(), 1'b1);
		alu_case(4'b1111, 1'b0, EXT_AM1, 16'h0001, rand16(), 1'b0);
		alu_case(4'b1111, 1'b0, EXT_AM1, 16'h0000, rand16(), 1'b0);
		alu_case(4'b1111, 1'b0, EXT_AM1, rand16(), rand16(), 1'b1);
		// logic functions through AT
		alu_case(4'b1011, 1'b1, EXT_AM1, rand16(), rand16(), 1'b0);
		alu_case(4'b1110, 1'b1, EXT_AM1, rand16(), rand16(), 1'b0);
		alu_case(4'b0110, 1'b1, EXT_AM1, rand16(), rand16(), 1'b0);
		alu_case(4'b0000, 1'b1, EXT_AM1, rand16(), rand16(), 1'b0);
		alu_case(4'b1010, 1'b1, EXT_AM1, rand16(), rand16(), 1'b0);
		// AT shifts, conditions exx and exy
		alu_case(4'b0000, 1'b0, EXT_AP1, rand16(), rand16(), 1'b0);
		for (int i = 0; i < 6; i++) begin
			s = idle_stim();
			s.ir = rand16();
			s.l = rand16();
			s.a_sel = A_L;
			s.w_sel = W_AT;
			s.axy = i[0];
			s.rctl.wx = 1'b1;
			s.rctl.eat0 = i[1];
			s.strb = STB_A;
			push_row(s);
		end
		// AR load, count up across the top byte, step back
		c = '0;
		c.w_ar = 1'b1;
		addr_row(c, STB_A, 16'h00fe, 1'b1, 1'b0);
		c = '0;
		c.arp1 = 1'b1;
		addr_row(c, STB_A, rand16(), 1'b1, 1'b0);
		addr_row(c, STB_A, rand16(), 1'b1, 1'b0);
		addr_row(c, STB_A, rand16(), 1'b1, 1'b0);
		c.arm4 = 1'b1;
		addr_row(c, STB_A, rand16(), 1'b1, 1'b0);
		addr_row(c, STB_A, rand16(), 1'b1, 1'b0);
		c = '0;
		c.w_ar = 1'b1;
		addr_row(c, STB_B, rand16(), 1'b1, 1'b0);
		// IC load, count, then both on the lines and off
		c = '0;
		c.w_ic = 1'b1;
		addr_row(c, STB_B, rand16(), 1'b0, 1'b1);
		c = '0;
		c.icp1 = 1'b1;
		addr_row(c, STB_A, rand16(), 1'b0, 1'b1);
		addr_row(c, STB_AT, rand16(), 1'b0, 1'b1);
		c = '0;
		addr_row(c, STB_A, rand16(), 1'b1, 1'b1);
		c.off = 1'b1;
		c.icp1 = 1'b1;
		addr_row(c, STB_A, rand16(), 1'b0, 1'b1);
		c = '0;
		addr_row(c, STB_A, rand16(), 1'b1, 1'b1);
		// key comparator hits and misses
		for (int i = 0; i < 6; i++) begin
			s = idle_stim();
			s.ar_ad = 1'b1;
			s.barnb = i[0];
			v = {~s.barnb, m_ar[14:0]};
			if (i[2:1] == 2'd1)
				v = v ^ 16'h0001;
			else if (i[2:1] == 2'd2)
				v = v ^ 16'h8000;
			s.kl = v;
			push_row(s);
		end
		push_row(idle_stim());
	endtask

	task automatic check(input string name, input logic [15:0] got_v,
			input logic [15:0] exp_v);
		if (got_v !== exp_v) begin
			$display("[FAIL] %s got %h exp %h", name, got_v, exp_v);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	always @(posedge __clk) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("the run went past its cycle limit without finishing");
			$display("sim failed");
			$fatal(1);
		end
	end

	initial begin
		resp_t      e;
		logic [4:0] m;
		drv = '0;
		rst = 1'b1;
		cycles = 0;
		limit = 0;
		rng = 32'he728;
		m_at = '0;
		m_ac = '0;
		m_ar = '0;
		m_ic = '0;
		m_wzi = 1'b0;
		m_wzi_ok = 1'b1;
		build_table();
		limit = stim_q.size() * 3 + 20;
		repeat (2) @(posedge __clk);
		rst <= 1'b0;
		foreach (stim_q[i]) begin
			@(posedge __clk);
			drv <= stim_q[i];
			@(negedge __clk);
			e = exp_q[i];
			m = mask_q[i];
			if (m[0]) begin
				check("w", got.w, e.w);
				check("ddt", got.ddt, e.ddt);
			end
			if (m[1]) begin
				check("dad", got.dad, e.dad);
				check("arz", 16'(got.arz), 16'(e.arz));
				check("zga", 16'(got.zga), 16'(e.zga));
			end
			if (m[2]) begin
				check("s0", 16'(got.s0), 16'(e.s0));
				check("carry", 16'(got.carry), 16'(e.carry));
				check("s_1", 16'(got.s_1), 16'(e.s_1));
				check("zs", 16'(got.zs), 16'(e.zs));
			end
			if (m[3])
				check("wzi", 16'(got.wzi), 16'(e.wzi));
			if (m[4]) begin
				check("at15", 16'(got.at15), 16'(e.at15));
				check("exx", 16'(got.exx), 16'(e.exx));
				check("exy", 16'(got.exy), 16'(e.exy));
			end
		end
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire
